// ==== bench/quad_mixer_golden.txt ====
// columns: rf lo_cos lo_sin exp_i exp_q ovf_i ovf_q, all hex, one item per line
// exp = bits 34:17 of rf*lo plus 2^16 (positive sign) or 2^16-1 (negative sign)
00001 010000 FF0000 00001 3FFFF 0 0
3FFFF 010000 FF0000 3FFFF 00001 0 0
00003 010000 FF0000 00002 3FFFE 0 0
3FFFD 010000 FF0000 3FFFE 00002 0 0
00005 018000 020000 00004 00005 0 0
3FFFB 018000 020000 3FFFC 3FFFB 0 0
0FFFF 010000 020000 08000 0FFFF 0 0
30001 010000 020000 38000 30001 0 0
00001 7FFFFF 800000 00040 3FFC0 0 0
3FFFF 7FFFFF 800000 3FFC0 00040 0 0
20000 FC0000 020000 00000 20000 1 0
20000 040000 FC0000 00000 00000 1 1
1FFFF 040000 020000 3FFFE 1FFFF 1 0
10000 040000 000000 20000 00000 1 0
00001 040000 FC0000 00002 3FFFE 0 0
00002 FC0000 018000 3FFFC 00002 0 0
3FFFE 018000 010000 3FFFE 3FFFF 0 0
12345 000000 020000 00000 12345 0 0
2ABCD 020000 000000 2ABCD 00000 0 0
00007 7FFFFF 020000 001C0 00007 0 0

// ==== verilog.f ====
logic/mixer_pkg.sv
logic/flow_pkg.sv
logic/mix_req_if.sv
logic/mixer_mul.sv
logic/credit_gate.sv
logic/quad_mixer_top.sv
bench/quad_mixer_checker.sv
bench/quad_mixer_tb.sv

// ==== Bender.yml ====
package:
  name: quad_mixer

sources:
  - logic/mixer_pkg.sv
  - logic/flow_pkg.sv
  - logic/mix_req_if.sv
  - logic/mixer_mul.sv
  - logic/credit_gate.sv
  - logic/quad_mixer_top.sv
  - target: test
    files:
      - bench/quad_mixer_checker.sv
      - bench/quad_mixer_tb.sv

// ==== bench/quad_mixer_tb.sv ====
`timescale 1ns/100ps

// drives the quadrature mixer from the golden file
// models the downstream buffer that hands credits back after a delay
module quad_mixer_tb;
	import mixer_pkg::*;
	import flow_pkg::*;

	localparam int N_ITEMS      = 20;	// lines in the golden file
	localparam int N_COLS       = 7;	// rf, cos, sin, i, q, ovf_i, ovf_q
	localparam int MAX_CRED_DLY = 6;	// longest random credit hold, in cycles
	localparam int MAX_GAP      = 3;	// longest random idle gap upstream
	localparam int N_PASSES     = 3;	// streams over the golden items
	localparam int TIMEOUT_CYC  =
		N_PASSES * N_ITEMS * (CREDIT_MAX + MAX_CRED_DLY + MUL_LATENCY) + 200;

	// credit model modes
	localparam int CRED_RANDOM = 0;
	localparam int CRED_PROMPT = 1;
	localparam int CRED_HOLD   = 2;

	logic    clk;
	logic    arst_n;
	logic    in_valid;
	sample_t in_rf;
	lo_t     in_lo_cos;
	lo_t     in_lo_sin;
	logic    in_ready;
	logic    out_valid;
	sample_t out_i;
	sample_t out_q;
	logic    out_ovf_i;
	logic    out_ovf_q;
	logic    credit_return;

	logic [31:0] gold [N_ITEMS*N_COLS];	// flat, N_COLS words per item

	int exp_q[$];	// golden index per accepted item, in order
	int acc_q[$];	// edge number of each acceptance
	int due_q[$];	// cycle at which a held credit may go back
	int cyc          = 0;	// rising edges seen so far
	int errors       = 0;
	int sent         = 0;
	int received     = 0;
	int credit_mode  = CRED_RANDOM;
	int tests_run    = 0;
	int tests_failed = 0;

	quad_mixer_top quad_mixer_top_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.in_rf         (in_rf),
		.in_lo_cos     (in_lo_cos),
		.in_lo_sin     (in_lo_sin),
		.in_ready      (in_ready),
		.out_valid     (out_valid),
		.out_i         (out_i),
		.out_q         (out_q),
		.out_ovf_i     (out_ovf_i),
		.out_ovf_q     (out_ovf_q),
		.credit_return (credit_return)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	// golden field access
	function automatic sample_t gold_sample(input int idx, input int col);
		return sample_t'(gold[idx*N_COLS+col][SAMPLE_W-1:0]);
	endfunction

	function automatic lo_t gold_lo(input int idx, input int col);
		return lo_t'(gold[idx*N_COLS+col][LO_W-1:0]);
	endfunction

	function automatic logic gold_flag(input int idx, input int col);
		return gold[idx*N_COLS+col][0];
	endfunction

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s got %h (%0d) expected %h (%0d)",
				$time, name, got, got, exp, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// edge counter and watchdog
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc > TIMEOUT_CYC) begin
			$display("timeout after %0d cycles, results stopped arriving", cyc);
			$display("%0d items sent, %0d received", sent, received);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// result monitor and downstream credit model, both on the falling edge
	always @(negedge clk) begin
		int idx;
		int acc;
		if (arst_n && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("result arrived at %0t with no item outstanding", $time);
				errors++;
			end else begin
				idx = exp_q.pop_front();
				acc = acc_q.pop_front();
				check_sample("out_i", out_i, gold_sample(idx, 3));
				check_sample("out_q", out_q, gold_sample(idx, 4));
				check_flag("out_ovf_i", out_ovf_i, gold_flag(idx, 5));
				check_flag("out_ovf_q", out_ovf_q, gold_flag(idx, 6));
				if (cyc + 1 - acc != MUL_LATENCY) begin	// seen at the next edge
					$display("** Error at %0t: latency got %0d expected %0d",
						$time, cyc + 1 - acc, MUL_LATENCY);
					errors++;
				end
				received++;
				if (credit_mode == CRED_PROMPT) begin
					due_q.push_back(cyc);
				end else begin
					due_q.push_back(cyc + $urandom_range(MAX_CRED_DLY, 0));
				end
			end
		end
		// at most one credit per cycle goes back
		if (credit_mode != CRED_HOLD && due_q.size() > 0 && due_q[0] <= cyc) begin
			credit_return = 1'b1;
			void'(due_q.pop_front());
		end else begin
			credit_return = 1'b0;
		end
	end

	// offer one item after an idle gap, return once it is taken
	task automatic send_item(input int idx, input int gap);
		repeat (gap) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
		@(negedge clk);
		in_valid  = 1'b1;
		in_rf     = gold_sample(idx, 0);
		in_lo_cos = gold_lo(idx, 1);
		in_lo_sin = gold_lo(idx, 2);
		while (!in_ready) @(negedge clk);	// in_ready only moves on rising edges
		exp_q.push_back(idx);
		acc_q.push_back(cyc + 1);	// taken at the coming edge
		sent++;
	endtask

	task automatic idle_input();
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (received < sent) @(negedge clk);
	endtask

	task automatic wait_credits_back();
		while (due_q.size() > 0) @(negedge clk);
		@(negedge clk);	// last return lands on the edge in between
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	initial begin
		int e0;
		void'($urandom(32'h146d_ba84));
		arst_n        = 1'b0;
		in_valid      = 1'b0;
		in_rf         = '0;
		in_lo_cos     = '0;
		in_lo_sin     = '0;
		credit_return = 1'b0;
		$readmemh("bench/quad_mixer_golden.txt", gold);

		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// reset state
		e0 = errors;
		@(negedge clk);
		check_flag("in_ready", in_ready, 1'b1);
		check_flag("out_valid", out_valid, 1'b0);
		end_test("reset_state", e0);

		// rounding, overflow and quadrature values with random gaps and credit delays
		e0 = errors;
		credit_mode = CRED_RANDOM;
		for (int i = 0; i < N_ITEMS; i++) begin
			send_item(i, $urandom_range(MAX_GAP, 0));
		end
		idle_input();
		wait_drained();
		wait_credits_back();
		end_test("rounding_overflow_quadrature", e0);

		// back to back with prompt credits, order and latency checked per result
		e0 = errors;
		credit_mode = CRED_PROMPT;
		for (int i = 0; i < N_ITEMS; i++) begin
			send_item(i, 0);
		end
		idle_input();
		wait_drained();
		wait_credits_back();
		end_test("throughput_order", e0);

		// credits withheld, ready has to drop after CREDIT_MAX accepts
		e0 = errors;
		credit_mode = CRED_HOLD;
		for (int i = 0; i < CREDIT_MAX; i++) begin
			send_item(i, 0);
		end
		idle_input();
		check_flag("in_ready", in_ready, 1'b0);
		wait_drained();	// items in flight still finish
		check_flag("in_ready", in_ready, 1'b0);
		credit_mode = CRED_PROMPT;	// hand the held credits back
		for (int i = CREDIT_MAX; i < N_ITEMS; i++) begin
			send_item(i, 0);
		end
		idle_input();
		wait_drained();
		wait_credits_back();
		check_flag("in_ready", in_ready, 1'b1);
		end_test("back_pressure", e0);

		errors += quad_mixer_top_inst.checker_inst.fail_count;	// bound assertions
		$display("%0d tests, %0d failed, %0d errors, %0d items sent, %0d received",
			tests_run, tests_failed, errors, sent, received);
		if (errors == 0 && tests_failed == 0 && sent == received) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule : quad_mixer_tb

// ==== bench/quad_mixer_checker.sv ====
`timescale 1ns/100ps

// protocol rules of the credit gate and the pipeline depth
module quad_mixer_checker (
	input logic              clk,
	input logic              arst_n,
	input logic              in_valid,
	input logic              in_ready,
	input logic              credit_return,
	input logic              out_valid,
	input flow_pkg::credit_t credits	// count inside the gate
);
	import flow_pkg::*;
	import mixer_pkg::*;

	int fail_count = 0;	// read by the testbench at the end
	int outstanding;	// downstream slots in use, seen from the handshakes

	// one more per accept, one less per returned credit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + ((in_valid && in_ready) ? 1 : 0)
				- (credit_return ? 1 : 0);
		end
	end

	// never more credits than downstream slots
	credit_max_a: assert property (
		@(posedge clk) disable iff (!arst_n)
		credits <= CREDIT_FULL
	) else begin
		fail_count++;
		$error("credit count %0d above %0d", credits, CREDIT_MAX);
	end

	// ready while a slot is free, low once all slots are taken
	ready_zero_a: assert property (
		@(posedge clk) disable iff (!arst_n)
		in_ready == (outstanding < CREDIT_MAX)
	) else begin
		fail_count++;
		$error("in_ready %b with %0d slots in use", in_ready, outstanding);
	end

	// every accept shows up MUL_LATENCY edges later
	latency_a: assert property (
		@(posedge clk) disable iff (!arst_n)
		(in_valid && in_ready) |-> ##MUL_LATENCY out_valid
	) else begin
		fail_count++;
		$error("accepted item without out_valid %0d cycles later", MUL_LATENCY);
	end

endmodule : quad_mixer_checker

bind quad_mixer_top quad_mixer_checker checker_inst (
	.clk           (clk),
	.arst_n        (arst_n),
	.in_valid      (in_valid),
	.in_ready      (in_ready),
	.credit_return (credit_return),
	.out_valid     (out_valid),
	.credits       (gate_inst.credits)
);

// ==== logic/quad_mixer_top.sv ====
`timescale 1ns/100ps

// quadrature mixer, rf times cosine LO on I, rf times sine LO on Q
// results go to a credit-managed buffer, 4 cycles from accept to out
module quad_mixer_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               in_valid,
	input  mixer_pkg::sample_t in_rf,	// signed rf sample
	input  mixer_pkg::lo_t     in_lo_cos,	// cosine LO word
	input  mixer_pkg::lo_t     in_lo_sin,	// sine LO word
	output logic               in_ready,
	output logic               out_valid,	// receiver must take it
	output mixer_pkg::sample_t out_i,
	output mixer_pkg::sample_t out_q,
	output logic               out_ovf_i,
	output logic               out_ovf_q,
	input  logic               credit_return	// one pulse per freed slot
);

	mix_req_if req_if ();	// accepted item, shared by both rails

	// credit count and input register
	credit_gate gate_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.in_rf         (in_rf),
		.in_lo_cos     (in_lo_cos),
		.in_lo_sin     (in_lo_sin),
		.credit_return (credit_return),
		.in_ready      (in_ready),
		.req           (req_if.gate)
	);

	// I rail, cosine LO
	mixer_mul #(.USE_SIN(1'b0)) mul_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req_if.mul),
		.res       (out_i),
		.res_ovf   (out_ovf_i),
		.res_valid (out_valid)	// stands for both rails
	);

	// Q rail, sine LO
	// same pipeline depth as I, so its valid matches and is left open
	mixer_mul #(.USE_SIN(1'b1)) mul_q (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req_if.mul),
		.res       (out_q),
		.res_ovf   (out_ovf_q),
		.res_valid ()
	);

endmodule : quad_mixer_top

// ==== logic/credit_gate.sv ====
`timescale 1ns/100ps

// holds one credit per free result slot downstream
// upstream is let in only while a slot is free, so the pipeline never stalls
module credit_gate (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               in_valid,	// upstream offers an item
	input  mixer_pkg::sample_t in_rf,
	input  mixer_pkg::lo_t     in_lo_cos,
	input  mixer_pkg::lo_t     in_lo_sin,
	input  logic               credit_return,	// one slot freed downstream
	output logic               in_ready,	// at least one credit left
	mix_req_if.gate            req	// registered item to both multipliers
);
	import flow_pkg::*;

	credit_t credits;	// free downstream slots
	logic    accept;	// upstream handshake this cycle

	// ready comes from the registered count only
	assign in_ready = (credits != CREDIT_NONE);
	assign accept   = in_valid & in_ready;

	// take one credit per accept, give one back per return
	// both on the same edge cancel out
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= CREDIT_FULL;	// all slots free
		end else begin
			case ({accept, credit_return})
				2'b10:   credits <= credits - credit_t'(1);
				2'b01:   credits <= credits + credit_t'(1);
				default: credits <= credits;	// idle or both
			endcase
		end
	end

	// valid pulse the cycle after acceptance
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req.valid <= 1'b0;
		end else begin
			req.valid <= accept;
		end
	end

	// item registers
	// loaded only on accept, so the rails see stable values between items
	always_ff @(posedge clk) begin
		if (accept) begin
			req.rf     <= in_rf;
			req.lo_cos <= in_lo_cos;
			req.lo_sin <= in_lo_sin;
		end
	end

endmodule : credit_gate

// ==== logic/mixer_mul.sv ====
`timescale 1ns/100ps

// signed 18x24 multiply, rounded back to 18 bits
// three register stages here, the input register sits in the credit gate
module mixer_mul #(
	parameter bit USE_SIN = 1'b0	// 0 gives the I rail, 1 the Q rail
) (
	input  logic               clk,
	input  logic               arst_n,
	mix_req_if.mul             req,	// item from the credit gate
	output mixer_pkg::sample_t res,	// rounded product bits 34:17
	output logic               res_ovf,	// rounded product left the range
	output logic               res_valid	// one pulse per item
);
	import mixer_pkg::*;

	lo_t      lo_sel;	// LO for this rail
	product_t prod_s1;	// full product
	logic     neg_s1;	// sign of the product from the input signs
	logic     vld_s1;
	product_t sum_s2;	// product plus rounding offset
	logic     vld_s2;

	// fixed per instance, so this folds away to plain wires
	assign lo_sel = USE_SIN ? req.lo_sin : req.lo_cos;

	// stage 1, multiply
	// both operands are signed, they get extended to the 42-bit target
	always_ff @(posedge clk) begin
		prod_s1 <= req.rf * lo_sel;
		neg_s1  <= req.rf[SAMPLE_W-1] ^ lo_sel[LO_W-1];	// known before the product
	end

	// stage 2, add half an output LSB
	// positive products round half up, negative ones round half away from zero
	// a zero input may give neg_s1 set, the offset still leaves 0
	always_ff @(posedge clk) begin
		if (neg_s1) begin
			sum_s2 <= prod_s1 + RND_NEG_OFS;
		end else begin
			sum_s2 <= prod_s1 + RND_POS_OFS;
		end
	end

	// stage 3, keep bits OUT_MSB..OUT_LSB
	always_ff @(posedge clk) begin
		res     <= sum_s2[OUT_MSB:OUT_LSB];
		res_ovf <= sum_s2[GUARD_BIT] ^ sum_s2[OUT_MSB];	// guard differs from kept msb
	end

	// valid follows the data through all three stages
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_s1    <= 1'b0;
			vld_s2    <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			vld_s1    <= req.valid;
			vld_s2    <= vld_s1;
			res_valid <= vld_s2;
		end
	end

endmodule : mixer_mul

// ==== logic/mix_req_if.sv ====
`timescale 1ns/100ps

// one accepted item, handed from the credit gate to both rails
// no handshake back, the multipliers never stall
interface mix_req_if;
	import mixer_pkg::*;

	logic    valid;	// single-cycle pulse per item
	sample_t rf;	// rf sample, shared by I and Q
	lo_t     lo_cos;	// cosine LO, I rail
	lo_t     lo_sin;	// sine LO, Q rail

	// credit gate side, owns the item registers
	modport gate (
		output valid,
		output rf,
		output lo_cos,
		output lo_sin
	);

	// multiplier side
	// each rail picks its own LO out of the two
	modport mul (
		input valid,
		input rf,
		input lo_cos,
		input lo_sin
	);

endinterface : mix_req_if

// ==== logic/flow_pkg.sv ====
package flow_pkg;

	// result slots the downstream buffer offers
	// also the most items that can be in flight between in and out
	localparam int CREDIT_MAX = 8;

	// counter has to hold CREDIT_MAX itself, not only CREDIT_MAX-1
	localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);	// 4 bits for 0..8

	typedef logic [CREDIT_W-1:0] credit_t;	// unsigned credit count

	// count value loaded at reset, every slot free
	localparam credit_t CREDIT_FULL = credit_t'(CREDIT_MAX);

	// count value where upstream has to be held off
	localparam credit_t CREDIT_NONE = '0;

endpackage : flow_pkg

// ==== logic/mixer_pkg.sv ====
package mixer_pkg;

	// widths of the mixer datapath
	localparam int SAMPLE_W = 18;	// rf sample and mixed output
	localparam int LO_W     = 24;	// cosine and sine LO words
	localparam int PROD_W   = SAMPLE_W + LO_W;	// full signed product

	typedef logic signed [SAMPLE_W-1:0] sample_t;	// rf in, I or Q out
	typedef logic signed [LO_W-1:0]     lo_t;	// one LO rail
	typedef logic signed [PROD_W-1:0]   product_t;	// 42-bit product

	// acceptance to result, gate register plus three multiplier stages
	localparam int MUL_LATENCY = 4;

	// the half-LSB offset is built from this product bit
	localparam int ROUND_POS = 16;

	// product bits kept in the rounded output
	localparam int OUT_LSB = 17;
	localparam int OUT_MSB = 34;	// OUT_MSB - OUT_LSB + 1 == SAMPLE_W

	// one bit above the kept field
	// a difference from OUT_MSB means the result wrapped
	localparam int GUARD_BIT = 35;

	// rounding offsets for the two product signs
	// a negative product gets one less so that halves round away from zero
	localparam product_t RND_POS_OFS = product_t'(1) << ROUND_POS;
	localparam product_t RND_NEG_OFS = RND_POS_OFS - product_t'(1);

endpackage : mixer_pkg
